// ==== common/mips_pkg.sv ====
package mips_pkg;

  typedef logic [31:0] word_t;      // data or byte address
  typedef logic [4:0]  reg_addr_t;  // register number
  typedef logic [5:0]  mem_index_t; // word index, address bits 7:2
  typedef logic [15:0] imm_t;       // raw immediate field
  typedef logic [25:0] target_t;    // raw jump target field

  // primary opcodes
  typedef enum logic [5:0] {
    op_rtype = 6'h00,
    op_j     = 6'h02,
    op_jal   = 6'h03,
    op_beq   = 6'h04,
    op_bne   = 6'h05,
    op_addi  = 6'h08,
    op_andi  = 6'h0c,
    op_ori   = 6'h0d,
    op_lw    = 6'h23,
    op_sw    = 6'h2b
  } opcode_e;

  // function codes under op_rtype
  typedef enum logic [5:0] {
    fn_jr  = 6'h08,
    fn_add = 6'h20,
    fn_sub = 6'h22,
    fn_and = 6'h24,
    fn_or  = 6'h25,
    fn_slt = 6'h2a
  } funct_e;

  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_slt = 3'd4
  } alu_op_e;

  typedef enum logic [1:0] {pc_seq, pc_branch, pc_jump, pc_reg} pc_sel_e;
  typedef enum logic [1:0] {wb_alu, wb_mem, wb_link} wb_sel_e;
  typedef enum logic [1:0] {dst_rt, dst_rd, dst_ra} dst_sel_e;

  // r-type layout, i and j forms overlay the low bits
  typedef struct packed {
    opcode_e   opcode;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    logic [4:0] shamt;
    funct_e    funct;
  } instr_t;

  typedef struct packed {
    pc_sel_e  pc_sel;
    logic     branch_ne; // bne rather than beq
    logic     is_branch;
    logic     sign_ext;  // 0 zero-extends the immediate
    logic     use_imm;   // alu b from immediate
    alu_op_e  alu_op;
    logic     dm_wen;
    logic     rf_wen;
    dst_sel_e dst_sel;
    wb_sel_e  wb_sel;
  } ctrl_t;

  // one retired instruction
  typedef struct packed {
    logic      valid;
    word_t     pc;
    logic      rf_wen;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;
    logic      dm_wen;
    word_t     dm_addr;
    word_t     dm_wdata;
  } retire_t;

  function automatic imm_t instr_imm(instr_t i);
    return {i.rd, i.shamt, i.funct}; // low 16 bits
  endfunction

  function automatic target_t instr_target(instr_t i);
    return {i.rs, i.rt, i.rd, i.shamt, i.funct}; // low 26 bits
  endfunction

endpackage

// ==== rtl/controller.sv ====
`timescale 1ns/1ps

module controller import mips_pkg::*; (
  input  opcode_e opcode,
  input  funct_e  funct,
  output ctrl_t   ctrl
);

  // no write, pc+4, used for anything not decoded
  localparam ctrl_t nop_ctrl = '{
    pc_sel:    pc_seq,
    branch_ne: 1'b0,
    is_branch: 1'b0,
    sign_ext:  1'b1,
    use_imm:   1'b0,
    alu_op:    alu_add,
    dm_wen:    1'b0,
    rf_wen:    1'b0,
    dst_sel:   dst_rt,
    wb_sel:    wb_alu
  };

  always_comb begin
    ctrl = nop_ctrl;
    case (opcode)
      op_rtype: begin
        ctrl.dst_sel = dst_rd; // r-type writes rd
        case (funct)
          fn_add: begin
            ctrl.alu_op = alu_add;
            ctrl.rf_wen = 1'b1;
          end
          fn_sub: begin
            ctrl.alu_op = alu_sub;
            ctrl.rf_wen = 1'b1;
          end
          fn_and: begin
            ctrl.alu_op = alu_and;
            ctrl.rf_wen = 1'b1;
          end
          fn_or: begin
            ctrl.alu_op = alu_or;
            ctrl.rf_wen = 1'b1;
          end
          fn_slt: begin
            ctrl.alu_op = alu_slt;
            ctrl.rf_wen = 1'b1;
          end
          fn_jr:   ctrl.pc_sel = pc_reg; // jump to rs, no write
          default: ctrl = nop_ctrl;
        endcase
      end
      op_addi: begin
        ctrl.use_imm = 1'b1;
        ctrl.rf_wen  = 1'b1; // sign_ext already set
      end
      op_andi, op_ori: begin
        ctrl.use_imm  = 1'b1;
        ctrl.sign_ext = 1'b0; // logical immediates zero-extend
        ctrl.alu_op   = (opcode == op_andi) ? alu_and : alu_or;
        ctrl.rf_wen   = 1'b1;
      end
      op_lw: begin
        ctrl.use_imm = 1'b1; // base + offset
        ctrl.rf_wen  = 1'b1;
        ctrl.wb_sel  = wb_mem;
      end
      op_sw: begin
        ctrl.use_imm = 1'b1;
        ctrl.dm_wen  = 1'b1;
      end
      op_beq, op_bne: begin
        ctrl.pc_sel    = pc_branch;
        ctrl.is_branch = 1'b1;
        ctrl.branch_ne = (opcode == op_bne);
        ctrl.alu_op    = alu_sub; // rs - rt, zero when equal
      end
      op_j: ctrl.pc_sel = pc_jump;
      op_jal: begin
        ctrl.pc_sel  = pc_jump;
        ctrl.rf_wen  = 1'b1;
        ctrl.dst_sel = dst_ra; // link into r31
        ctrl.wb_sel  = wb_link;
      end
      default: ctrl = nop_ctrl;
    endcase
  end

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu import mips_pkg::*; (
  input  word_t   a,
  input  word_t   b,
  input  alu_op_e op,
  output word_t   result,
  output logic    zero
);

  logic lt_signed;

  // signed compare for slt
  assign lt_signed = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      alu_add: result = a + b;
      alu_sub: result = a - b; // also used for beq / bne
      alu_and: result = a & b;
      alu_or:  result = a | b;
      alu_slt: result = {31'b0, lt_signed};
      default: result = '0;
    endcase
  end

  // feeds the branch decision in fetch
  assign zero = (result == '0);

endmodule

// ==== regfile/regfile.sv ====
`timescale 1ns/1ps

module regfile import mips_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  reg_addr_t raddr_a,
  input  reg_addr_t raddr_b,
  input  reg_addr_t waddr,
  input  logic      wen,
  input  word_t     wdata,
  output word_t     rdata_a,
  output word_t     rdata_b
);

  word_t regs [32]; // contents survive reset

  always_ff @(posedge clk) begin
    // r0 is never stored, held off while in reset
    if (wen && !reset && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // combinational reads, r0 reads as zero
  assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
  assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import mips_pkg::*; #(
  parameter word_t reset_pc = '0
) (
  input  logic    clk,
  input  logic    reset,
  input  pc_sel_e pc_sel,
  input  logic    is_branch,
  input  logic    branch_ne,
  input  logic    zero,
  input  word_t   imm,      // already extended
  input  target_t target,
  input  word_t   rs_data,
  output word_t   pc,
  output word_t   pc_plus4
);

  logic  taken;
  word_t branch_pc;
  word_t jump_pc;
  word_t next_pc;

  assign pc_plus4  = pc + 32'd4;
  assign taken     = is_branch & (zero ^ branch_ne); // beq on zero, bne on not zero
  assign branch_pc = pc_plus4 + {imm[29:0], 2'b00};
  assign jump_pc   = {pc_plus4[31:28], target, 2'b00}; // stays in the 256MB region

  always_comb begin
    case (pc_sel)
      pc_branch: next_pc = taken ? branch_pc : pc_plus4;
      pc_jump:   next_pc = jump_pc;
      pc_reg:    next_pc = rs_data; // jr
      default:   next_pc = pc_plus4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

// ==== rtl/instruction_memory.sv ====
`timescale 1ns/1ps

module instruction_memory import mips_pkg::*; #(
  parameter int imem_words = 64
) (
  input  logic       clk,
  input  logic       wen,   // load port, only used under reset
  input  mem_index_t waddr,
  input  word_t      wdata,
  input  word_t      pc,
  output word_t      instr
);

  word_t      mem [imem_words];
  mem_index_t rd_idx;

  always_ff @(posedge clk) begin
    if (wen) begin
      mem[waddr] <= wdata;
    end
  end

  assign rd_idx = pc[7:2]; // word index, low bits dropped
  assign instr  = mem[rd_idx];

endmodule

// ==== rtl/data_memory.sv ====
`timescale 1ns/1ps

module data_memory import mips_pkg::*; #(
  parameter int dmem_words = 64
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  wen,
  input  word_t addr,   // byte address from the alu
  input  word_t wdata,
  output word_t rdata
);

  word_t      mem [dmem_words]; // not cleared by reset
  mem_index_t idx;

  // word addressed, bits above 7 wrap
  assign idx = addr[7:2];

  always_ff @(posedge clk) begin
    if (wen && !reset) begin
      mem[idx] <= wdata;
    end
  end

  assign rdata = mem[idx]; // async read for lw in the same cycle

endmodule

// ==== rtl/cpu.sv ====
`timescale 1ns/1ps

module cpu import mips_pkg::*; #(
  parameter int    imem_words = 64,
  parameter int    dmem_words = 64,
  parameter word_t reset_pc   = '0
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       imem_wen,
  input  mem_index_t imem_addr,
  input  word_t      imem_wdata,
  output retire_t    retire
);

  word_t     pc, pc_plus4;
  word_t     instr_word;
  instr_t    ins;
  ctrl_t     ctrl;
  imm_t      imm16;
  word_t     imm_ext;
  word_t     rs_data, rt_data;
  word_t     alu_b, alu_result;
  logic      alu_zero;
  word_t     dm_rdata;
  word_t     wb_data;
  reg_addr_t wb_addr;
  logic      rf_wen, dm_wen;

  fetch_unit #(.reset_pc(reset_pc)) i_fetch_unit (
    .clk, .reset,
    .pc_sel(ctrl.pc_sel), .is_branch(ctrl.is_branch), .branch_ne(ctrl.branch_ne),
    .zero(alu_zero), .imm(imm_ext), .target(instr_target(ins)), .rs_data,
    .pc, .pc_plus4
  );

  instruction_memory #(.imem_words(imem_words)) i_instruction_memory (
    .clk, .wen(imem_wen), .waddr(imem_addr), .wdata(imem_wdata), .pc, .instr(instr_word)
  );

  assign ins   = instr_t'(instr_word); // field view of the fetched word
  assign imm16 = instr_imm(ins);

  controller i_controller (.opcode(ins.opcode), .funct(ins.funct), .ctrl);

  // no commits while held in reset
  assign rf_wen = ctrl.rf_wen & ~reset;
  assign dm_wen = ctrl.dm_wen & ~reset;

  regfile i_regfile (
    .clk, .reset, .raddr_a(ins.rs), .raddr_b(ins.rt), .waddr(wb_addr),
    .wen(rf_wen), .wdata(wb_data), .rdata_a(rs_data), .rdata_b(rt_data)
  );

  // andi / ori take the zero-extended form
  assign imm_ext = ctrl.sign_ext ? {{16{imm16[15]}}, imm16} : {16'b0, imm16};
  assign alu_b   = ctrl.use_imm ? imm_ext : rt_data;

  alu i_alu (.a(rs_data), .b(alu_b), .op(ctrl.alu_op), .result(alu_result), .zero(alu_zero));

  data_memory #(.dmem_words(dmem_words)) i_data_memory (
    .clk, .reset, .wen(dm_wen), .addr(alu_result), .wdata(rt_data), .rdata(dm_rdata)
  );

  always_comb begin
    case (ctrl.wb_sel)
      wb_mem:  wb_data = dm_rdata;
      wb_link: wb_data = pc_plus4; // jal return address
      default: wb_data = alu_result;
    endcase
    case (ctrl.dst_sel)
      dst_rd:  wb_addr = ins.rd;
      dst_ra:  wb_addr = 5'd31;
      default: wb_addr = ins.rt;
    endcase
  end

  // describes the instruction committing at the next edge
  assign retire = '{
    valid:    ~reset,
    pc:       pc,
    rf_wen:   rf_wen,
    rf_waddr: wb_addr,
    rf_wdata: wb_data,
    dm_wen:   dm_wen,
    dm_addr:  alu_result,
    dm_wdata: rt_data
  };

endmodule

// ==== tests/cpu_assertions.sv ====
`timescale 1ns/1ps

module cpu_assertions import mips_pkg::*; #(
  parameter word_t reset_pc = '0
) (
  input logic    clk,
  input logic    reset,
  input word_t   pc,
  input retire_t retire
);

  int failures; // assertion failures so far

  initial failures = 0;

  // nothing retires under reset, first retire after it starts at the reset vector
  valid_low_in_reset: assert property (
    @(posedge clk) retire.valid |-> !reset && (!$past(reset) || retire.pc == reset_pc)
  ) else begin
    $error("retire.valid under reset, or first retire pc %h off the reset vector",
           retire.pc);
    failures++;
  end

  // r0 is hardwired, a write to it is a decode fault
  no_write_to_r0: assert property (
    @(posedge clk) retire.rf_wen |-> (retire.rf_waddr != 5'd0)
  ) else begin
    $error("register write aimed at r0 from pc %h", retire.pc);
    failures++;
  end

  // jr targets come from links, so they stay aligned too
  pc_word_aligned: assert property (
    @(posedge clk) disable iff (reset) pc[1:0] == 2'b00
  ) else begin
    $error("pc %h is not word aligned", pc);
    failures++;
  end

endmodule

// ==== tests/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb import mips_pkg::*; ();

  localparam word_t       reset_pc   = '0;
  localparam int          prog_len   = 40;
  localparam int          num_tests  = 8;
  localparam int          max_cycles = 1000;
  localparam int unsigned seed       = 32'h029c8f05;

  // what each program slot holds before encoding
  typedef enum int {
    k_init, k_alu, k_addi, k_logic, k_sw, k_lw, k_branch, k_jump,
    k_call, k_call_j, k_call_jr, k_end
  } slot_e;

  logic       clk;
  logic       reset;
  logic       imem_wen;
  mem_index_t imem_addr;
  word_t      imem_wdata;
  retire_t    retire;

  word_t prog [64];       // program image, also the model's imem
  slot_e kind [prog_len];
  bit    safe [prog_len]; // slots a forward branch may land on
  word_t m_regs [32];
  word_t m_mem [64];
  word_t m_pc;
  int    n_words;
  int    end_idx;         // self-loop slot
  int    checks;
  int    test_errors;
  int    total_errors;
  int    tests_run;
  int    tests_failed;
  bit    timed_out;

  cpu #(.imem_words(64), .dmem_words(64), .reset_pc(reset_pc)) i_cpu (
    .clk, .reset, .imem_wen, .imem_addr, .imem_wdata, .retire
  );

  bind cpu cpu_assertions #(.reset_pc(reset_pc)) i_cpu_assertions (
    .clk(clk), .reset(reset), .pc(pc), .retire(retire)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  task automatic next_edge();
    @(posedge clk);
    #1; // drive just after the edge
  endtask

  function automatic word_t r_type_word(funct_e fn, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd);
    return {op_rtype, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic word_t i_type_word(opcode_e op, reg_addr_t rs, reg_addr_t rt,
                                        logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t j_type_word(opcode_e op, int idx);
    return {op, 26'(idx)}; // word index, upper pc bits stay zero
  endfunction

  function automatic reg_addr_t source_reg();
    return 5'($urandom_range(8, 0));
  endfunction

  function automatic reg_addr_t dest_reg();
    return 5'($urandom_range(8, 1)); // never r0, never r31
  endfunction

  // few words so that sw and lw meet often
  function automatic logic [15:0] mem_offset();
    return 16'($urandom_range(15, 0) * 4);
  endfunction

  function automatic funct_e random_funct();
    case ($urandom_range(4, 0))
      0:       return fn_add;
      1:       return fn_sub;
      2:       return fn_and;
      3:       return fn_or;
      default: return fn_slt;
    endcase
  endfunction

  function automatic int forward_target(int from);
    int t;
    for (int tries = 0; tries < 8; tries++) begin
      t = $urandom_range(prog_len - 1, from + 1);
      if (safe[t]) return t;
    end
    return prog_len - 1; // self-loop is always a legal landing
  endfunction

  // stores each address into its own word, loops back with bne
  task automatic build_fill_program();
    prog[0] = i_type_word(op_addi, 5'd0, 5'd1, 16'd0);
    prog[1] = i_type_word(op_addi, 5'd0, 5'd2, 16'd256); // one past the last word
    prog[2] = i_type_word(op_sw, 5'd1, 5'd1, 16'd0);
    prog[3] = i_type_word(op_addi, 5'd1, 5'd1, 16'd4);
    prog[4] = i_type_word(op_bne, 5'd1, 5'd2, 16'hfffd); // back to slot 2
    prog[5] = j_type_word(op_j, 5);
    n_words = 6;
    end_idx = 5;
  endtask

  task automatic build_random_program();
    int i;
    int sel;
    for (int k = 0; k < prog_len; k++)
      safe[k] = 1'b1;
    for (int k = 0; k < 8; k++)
      kind[k] = k_init; // r1..r8 seeded by addi
    i = 8;
    while (i < prog_len - 1) begin
      sel = $urandom_range(9, 0);
      if (sel == 8 && i <= prog_len - 4) begin
        kind[i]     = k_call;    // jal to i+2
        kind[i + 1] = k_call_j;  // link lands here, skips the jr
        kind[i + 2] = k_call_jr;
        safe[i + 1] = 1'b0;
        safe[i + 2] = 1'b0;      // jr only reachable through jal
        i += 3;
      end else begin
        case (sel)
          2:       kind[i] = k_addi;
          3:       kind[i] = k_logic;
          4:       kind[i] = k_sw;
          5:       kind[i] = k_lw;
          6:       kind[i] = k_branch;
          7:       kind[i] = k_jump;
          default: kind[i] = k_alu;
        endcase
        i++;
      end
    end
    kind[prog_len - 1] = k_end;
    for (int k = 0; k < prog_len; k++) begin
      case (kind[k])
        k_init:    prog[k] = i_type_word(op_addi, 5'd0, 5'(k + 1), 16'($urandom));
        k_alu:     prog[k] = r_type_word(random_funct(), source_reg(), source_reg(), dest_reg());
        k_addi:    prog[k] = i_type_word(op_addi, source_reg(), dest_reg(), 16'($urandom));
        k_logic:   prog[k] = i_type_word($urandom_range(1, 0) ? op_andi : op_ori,
                                         source_reg(), dest_reg(), 16'($urandom));
        k_sw:      prog[k] = i_type_word(op_sw, 5'd0, source_reg(), mem_offset());
        k_lw:      prog[k] = i_type_word(op_lw, 5'd0, dest_reg(), mem_offset());
        k_branch:  prog[k] = i_type_word($urandom_range(1, 0) ? op_beq : op_bne,
                                         source_reg(), source_reg(),
                                         16'(forward_target(k) - k - 1));
        k_jump:    prog[k] = j_type_word(op_j, forward_target(k));
        k_call:    prog[k] = j_type_word(op_jal, k + 2);
        k_call_j:  prog[k] = j_type_word(op_j, k + 2);
        k_call_jr: prog[k] = r_type_word(fn_jr, 5'd31, 5'd0, 5'd0);
        default:   prog[k] = j_type_word(op_j, k); // final self-loop
      endcase
    end
    n_words = prog_len;
    end_idx = prog_len - 1;
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    checks++;
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_idle();
    checks++;
    assert (!retire.valid && !retire.rf_wen && !retire.dm_wen) else begin
      $display("Mismatch at %0t ns: retire active under reset (valid %b rf_wen %b dm_wen %b)",
               $time, retire.valid, retire.rf_wen, retire.dm_wen);
      test_errors++;
    end
  endtask

  // instruction-set model, one instruction per call
  task automatic model_step(output retire_t exp);
    word_t      ins;
    word_t      a;
    word_t      b;
    word_t      imm_s;
    word_t      eff_addr;
    word_t      next_pc;
    logic [5:0] op;
    logic [5:0] fn;
    ins      = prog[m_pc[7:2]];
    op       = ins[31:26];
    fn       = ins[5:0];
    a        = m_regs[ins[25:21]];
    b        = m_regs[ins[20:16]];
    imm_s    = {{16{ins[15]}}, ins[15:0]};
    eff_addr = a + imm_s;
    next_pc  = m_pc + 32'd4;
    exp          = '0;
    exp.valid    = 1'b1;
    exp.pc       = m_pc;
    exp.rf_waddr = ins[20:16]; // i-type default
    case (op)
      op_rtype: begin
        exp.rf_wen   = 1'b1;
        exp.rf_waddr = ins[15:11];
        case (fn)
          fn_add:  exp.rf_wdata = a + b;
          fn_sub:  exp.rf_wdata = a - b;
          fn_and:  exp.rf_wdata = a & b;
          fn_or:   exp.rf_wdata = a | b;
          fn_slt:  exp.rf_wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          fn_jr: begin
            exp.rf_wen = 1'b0;
            next_pc    = a;
          end
          default: exp.rf_wen = 1'b0;
        endcase
      end
      op_addi: begin
        exp.rf_wen   = 1'b1;
        exp.rf_wdata = a + imm_s;
      end
      op_andi: begin
        exp.rf_wen   = 1'b1;
        exp.rf_wdata = a & {16'h0, ins[15:0]}; // zero-extended
      end
      op_ori: begin
        exp.rf_wen   = 1'b1;
        exp.rf_wdata = a | {16'h0, ins[15:0]};
      end
      op_lw: begin
        exp.rf_wen   = 1'b1;
        exp.rf_wdata = m_mem[eff_addr[7:2]];
      end
      op_sw: begin
        exp.dm_wen   = 1'b1;
        exp.dm_addr  = eff_addr;
        exp.dm_wdata = b;
      end
      op_beq:  if (a == b) next_pc = next_pc + (imm_s << 2);
      op_bne:  if (a != b) next_pc = next_pc + (imm_s << 2);
      op_j:    next_pc = {next_pc[31:28], ins[25:0], 2'b00};
      op_jal: begin
        exp.rf_wen   = 1'b1;
        exp.rf_waddr = 5'd31;
        exp.rf_wdata = next_pc; // link is pc+4
        next_pc      = {next_pc[31:28], ins[25:0], 2'b00};
      end
      default: ;
    endcase
    if (exp.rf_wen && exp.rf_waddr != 5'd0)
      m_regs[exp.rf_waddr] = exp.rf_wdata;
    if (exp.dm_wen)
      m_mem[exp.dm_addr[7:2]] = exp.dm_wdata;
    m_pc = next_pc;
  endtask

  // data fields only mean something with their enable
  task automatic compare_retire(input retire_t exp);
    check_word("valid", word_t'(retire.valid), word_t'(exp.valid));
    check_word("pc", retire.pc, exp.pc);
    check_word("rf_wen", word_t'(retire.rf_wen), word_t'(exp.rf_wen));
    if (exp.rf_wen) begin
      check_word("rf_waddr", word_t'(retire.rf_waddr), word_t'(exp.rf_waddr));
      check_word("rf_wdata", retire.rf_wdata, exp.rf_wdata);
    end
    check_word("dm_wen", word_t'(retire.dm_wen), word_t'(exp.dm_wen));
    if (exp.dm_wen) begin
      check_word("dm_addr", retire.dm_addr, exp.dm_addr);
      check_word("dm_wdata", retire.dm_wdata, exp.dm_wdata);
    end
  endtask

  task automatic load_program();
    reset    = 1'b1;
    imem_wen = 1'b0;
    for (int c = 0; c < 2; c++) begin
      @(negedge clk);
      check_idle();
      next_edge();
    end
    for (int w = 0; w < n_words; w++) begin // reset stays high while loading
      imem_wen   = 1'b1;
      imem_addr  = mem_index_t'(w);
      imem_wdata = prog[w];
      @(negedge clk);
      check_idle();
      next_edge();
    end
    imem_wen = 1'b0;
    reset    = 1'b0;
  endtask

  task automatic run_program(output int retired);
    retire_t exp;
    int      cycles;
    bit      done;
    m_pc    = reset_pc;
    retired = 0;
    cycles  = 0;
    done    = 1'b0;
    while (!done && !timed_out) begin
      @(negedge clk); // outputs settled mid-cycle
      if (retired == 0)
        check_word("first retire pc", retire.pc, reset_pc);
      model_step(exp);
      compare_retire(exp);
      retired++;
      cycles++;
      done = (retire.pc == word_t'(end_idx * 4));
      if (!done && cycles >= max_cycles) begin
        $display("the core did not reach its final self-loop within %0d cycles", max_cycles);
        test_errors++;
        timed_out = 1'b1;
      end
      next_edge();
    end
  endtask

  task automatic finish_run();
    total_errors += i_cpu.i_cpu_assertions.failures; // bound checker counts too
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, total_errors);
    if (total_errors == 0 && !timed_out)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  endtask

  initial begin
    int    retired;
    string name;
    reset        = 1'b1;
    imem_wen     = 1'b0;
    imem_addr    = '0;
    imem_wdata   = '0;
    checks       = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    void'($urandom(seed));
    for (int r = 0; r < 32; r++)
      m_regs[r] = '0;
    next_edge();
    for (int t = 0; t < num_tests && !timed_out; t++) begin
      test_errors = 0;
      if (t == 0) begin
        name = "memory fill";      // gives every data word a known value
        build_fill_program();
      end else begin
        name = "random program";
        build_random_program();
      end
      load_program();
      run_program(retired);
      tests_run++;
      if (test_errors != 0)
        tests_failed++;
      total_errors += test_errors;
      $display("test %0d %s: %s, %0d retired, %0d errors",
               t, name, (test_errors == 0) ? "ok" : "FAILED", retired, test_errors);
    end
    finish_run();
  end

endmodule

// ==== vlog.f ====
common/mips_pkg.sv
rtl/controller.sv
rtl/alu.sv
regfile/regfile.sv
rtl/fetch_unit.sv
rtl/instruction_memory.sv
rtl/data_memory.sv
rtl/cpu.sv
tests/cpu_assertions.sv
tests/cpu_tb.sv

// ==== Makefile ====
# Verilator build and run for the single-cycle MIPS core

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Done: no errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
